/* hw/bank_pkg.sv */
// Four accounts are fixed by the 2-bit index; hash_key is meant only for constant reset values
package bank_pkg;

	localparam int NUM_ACCOUNTS = 4;

	// Folded into the state on every hash round
	localparam logic [15:0] HASH_SALT = 16'hA5C3;

	// Sequencer stages, one transaction at a time
	typedef enum logic [2:0] {
		IDLE  = 3'd0,
		READ  = 3'd1,
		HASH  = 3'd2,
		CHECK = 3'd3,
		STORE = 3'd4
	} txn_step_t;

	typedef enum logic {
		WITHDRAW = 1'b0,
		DEPOSIT  = 1'b1
	} txn_op_t;

	typedef enum logic [1:0] {
		OK       = 2'd0,
		BAD_KEY  = 2'd1,
		NO_FUNDS = 2'd2
	} txn_status_t;

	// Captured from the switches, held until the transaction finishes
	typedef struct packed {
		logic [1:0] account;
		txn_op_t    op;
		logic [7:0] amount;
		logic [7:0] key;
	} txn_request_t;

	// One stored account
	typedef struct packed {
		logic [15:0] balance;
		logic [15:0] key_hash;
	} account_rec_t;

	typedef struct packed {
		logic [1:0]  account;
		txn_status_t status;
		logic [15:0] balance;
	} txn_result_t;

	// Whole hash in one step: rotate left by 3, then XOR the salt, per round
	function automatic logic [15:0] hash_key(input logic [7:0] key, input int rounds);
		logic [15:0] state;
		state = {8'h00, key};
		for (int i = 0; i < rounds; i++)
		begin
			state = {state[12:0], state[15:13]} ^ HASH_SALT;
		end
		return state;
	endfunction

endpackage

/* hw/main_control.sv */
// Buttons are active low and assumed debounced; key[2] is not used; request holds until finished
module main_control
(
	input  logic                   clock,
	input  logic                   arst_n,
	input  logic [9:0]             sw,
	input  logic [3:0]             key,
	input  logic                   finished,
	output logic                   start_txn,
	output bank_pkg::txn_request_t request
);
	import bank_pkg::*;

	// Bit 0 withdraw, bit 1 load, bit 2 deposit
	logic [2:0] btn_q;
	logic [2:0] btn_qq;
	logic [2:0] press;
	logic       amount_loaded;
	logic       key_loaded;
	logic       busy;
	logic       load_amount;
	logic       load_key;
	logic       start_req;

	// Two-stage sample of the buttons, idle level is high
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			btn_q  <= '1;
			btn_qq <= '1;
		end
		else
		begin
			btn_q  <= {key[3], key[1], key[0]};
			btn_qq <= btn_q;
		end
	end

	// A press is the high to low edge
	assign press = btn_qq & ~btn_q;

	assign load_amount = press[1] && !busy && !amount_loaded;
	assign load_key    = press[1] && !busy && amount_loaded && !key_loaded;
	assign start_req   = (press[0] || press[2]) && amount_loaded && key_loaded && !busy;

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			start_txn     <= 1'b0;
			amount_loaded <= 1'b0;
			key_loaded    <= 1'b0;
			busy          <= 1'b0;
		end
		else
		begin
			start_txn <= start_req;
			if (finished)
			begin
				amount_loaded <= 1'b0;
				key_loaded    <= 1'b0;
				busy          <= 1'b0;
			end
			else
			begin
				if (start_req)
					busy <= 1'b1;
				if (load_amount)
					amount_loaded <= 1'b1;
				if (load_key)
					key_loaded <= 1'b1;
			end
		end
	end

	// Request fields, first load takes amount and account, second the key
	always_ff @(posedge clock)
	begin
		if (load_amount)
		begin
			request.amount  <= sw[7:0];
			request.account <= sw[9:8];
		end
		if (load_key)
			request.key <= sw[7:0];
		// Withdraw wins if both start buttons land together
		if (start_req)
			request.op <= press[0] ? WITHDRAW : DEPOSIT;
	end

	assert property (@(posedge clock) disable iff (!arst_n)
		start_txn |=> !start_txn);

endmodule

/* hw/transaction_control.sv */
// Single transaction in flight; CHECK always lasts one cycle, the other steps wait on their done
module transaction_control
(
	input  logic                clock,
	input  logic                arst_n,
	input  logic                start_txn,
	input  logic                mem_done,
	input  logic                hash_done,
	output bank_pkg::txn_step_t step,
	output logic                finished
);
	import bank_pkg::*;

	logic      step_done;
	txn_step_t next_step;

	// Which done signal ends the current step
	always_comb
	begin
		case (step)
			IDLE:    step_done = start_txn;
			READ:    step_done = mem_done;
			HASH:    step_done = hash_done;
			CHECK:   step_done = 1'b1;
			STORE:   step_done = mem_done;
			default: step_done = 1'b1;
		endcase
	end

	always_comb
	begin
		case (step)
			IDLE:    next_step = READ;
			READ:    next_step = HASH;
			HASH:    next_step = CHECK;
			CHECK:   next_step = STORE;
			default: next_step = IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
			step <= IDLE;
		else if (step_done)
			step <= next_step;
	end

	// Last STORE cycle, write already done
	assign finished = (step == STORE) && mem_done;

	// A start strobe only arrives while the sequencer is idle, so none is dropped
	assert property (@(posedge clock) disable iff (!arst_n)
		start_txn |-> step == IDLE);

	// Completion comes from a STORE that held through its write cycle
	assert property (@(posedge clock) disable iff (!arst_n)
		finished |-> (step == STORE) && ($past(step) == STORE));

endmodule

/* hw/datapath.sv */
// Hash takes HASH_ROUNDS cycles in HASH; result and new_rec hold from CHECK until the next CHECK
module datapath
#(
	parameter int HASH_ROUNDS = 5
)
(
	input  logic                   clock,
	input  logic                   arst_n,
	input  bank_pkg::txn_step_t    step,
	input  bank_pkg::txn_request_t request,
	input  bank_pkg::account_rec_t rec,
	output logic                   hash_done,
	output bank_pkg::account_rec_t new_rec,
	output logic                   write_en,
	output bank_pkg::txn_result_t  result
);
	import bank_pkg::*;

	localparam int CNT_W = (HASH_ROUNDS > 1) ? $clog2(HASH_ROUNDS) : 1;
	localparam logic [CNT_W-1:0] LAST_ROUND = CNT_W'(HASH_ROUNDS - 1);

	account_rec_t rec_q;
	logic [15:0]  hash_state;
	logic [CNT_W-1:0] round_cnt;
	logic [16:0]  sum;
	logic [15:0]  amount_ext;
	logic         key_ok;
	logic         funds_ok;
	txn_status_t  status;
	logic [15:0]  balance_next;

	// Last capture in READ is the settled record
	always_ff @(posedge clock)
	begin
		if (step == READ)
			rec_q <= rec;
	end

	// Round counter only runs in HASH
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
			round_cnt <= '0;
		else if (step == HASH)
			round_cnt <= round_cnt + 1'b1;
		else
			round_cnt <= '0;
	end

	// Seeded from the key outside HASH, one round per cycle inside
	always_ff @(posedge clock)
	begin
		if (step == HASH)
			hash_state <= {hash_state[12:0], hash_state[15:13]} ^ HASH_SALT;
		else
			hash_state <= {8'h00, request.key};
	end

	assign hash_done = (step == HASH) && (round_cnt == LAST_ROUND);

	assign amount_ext = {8'h00, request.amount};
	assign sum        = {1'b0, rec_q.balance} + {1'b0, amount_ext};
	assign key_ok     = (hash_state == rec_q.key_hash);
	assign funds_ok   = (amount_ext <= rec_q.balance);

	always_comb
	begin
		status       = OK;
		balance_next = rec_q.balance;
		if (!key_ok)
			status = BAD_KEY;
		else if (request.op == WITHDRAW)
		begin
			if (!funds_ok)
				status = NO_FUNDS;
			else
				balance_next = rec_q.balance - amount_ext;
		end
		else
		begin
			// Deposit saturates at the top of the range
			balance_next = sum[16] ? 16'hFFFF : sum[15:0];
		end
	end

	always_ff @(posedge clock)
	begin
		if (step == CHECK)
		begin
			result  <= '{account: request.account, status: status, balance: balance_next};
			new_rec <= '{balance: balance_next, key_hash: rec_q.key_hash};
		end
	end

	// High for the first STORE cycle only
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
			write_en <= 1'b0;
		else
			write_en <= (step == CHECK) && (status == OK);
	end

	// An accepted write never wraps the balance in either direction
	assert property (@(posedge clock) disable iff (!arst_n)
		write_en |-> (result.status == OK) && ((request.op == WITHDRAW) ?
			(new_rec.balance <= rec_q.balance) : (new_rec.balance >= rec_q.balance)));

endmodule

/* hw/memory_control.sv */
// Four records in flops; reset loads INIT_BALANCE and the hash of each index as its key
module memory_control
#(
	parameter int INIT_BALANCE = 200,
	parameter int HASH_ROUNDS  = 5
)
(
	input  logic                   clock,
	input  logic                   arst_n,
	input  bank_pkg::txn_step_t    step,
	input  logic [1:0]             account,
	input  bank_pkg::account_rec_t new_rec,
	input  logic                   write_en,
	output bank_pkg::account_rec_t rec,
	output logic                   mem_done
);
	import bank_pkg::*;

	account_rec_t mem [NUM_ACCOUNTS];
	logic         access;

	assign access = (step == READ) || (step == STORE);

	// Done one cycle after entering READ or STORE, then drops as the step moves on
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
			mem_done <= 1'b0;
		else
			mem_done <= access && !mem_done;
	end

	// Record array, write happens in the first STORE cycle
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < NUM_ACCOUNTS; i++)
			begin
				mem[i] <= '{balance: 16'(INIT_BALANCE), key_hash: hash_key(8'(i), HASH_ROUNDS)};
			end
		end
		else if (step == STORE && write_en && !mem_done)
			mem[account] <= new_rec;
	end

	always_ff @(posedge clock)
	begin
		if (step == READ)
			rec <= mem[account];
	end

	// The datapath only asks for a write on the cycle the array takes it
	assert property (@(posedge clock) disable iff (!arst_n)
		write_en |-> (step == STORE) && !mem_done);

endmodule

/* hw/main.sv */
// No display output; result is meaningful only while result_valid is high
module main
#(
	parameter int HASH_ROUNDS  = 5,
	parameter int INIT_BALANCE = 200
)
(
	input  logic                  clock,
	input  logic                  arst_n,
	input  logic [9:0]            sw,
	input  logic [3:0]            key,
	output bank_pkg::txn_result_t result,
	output logic                  result_valid
);
	import bank_pkg::*;

	logic         start_txn;
	logic         mem_done;
	logic         hash_done;
	logic         write_en;
	txn_step_t    step;
	txn_request_t request;
	account_rec_t rec;
	account_rec_t new_rec;

	// Finished doubles as the result strobe
	main_control u_main_control (
		.clock     (clock),
		.arst_n    (arst_n),
		.sw        (sw),
		.key       (key),
		.finished  (result_valid),
		.start_txn (start_txn),
		.request   (request)
	);

	transaction_control u_transaction_control (
		.clock     (clock),
		.arst_n    (arst_n),
		.start_txn (start_txn),
		.mem_done  (mem_done),
		.hash_done (hash_done),
		.step      (step),
		.finished  (result_valid)
	);

	datapath #(
		.HASH_ROUNDS (HASH_ROUNDS)
	) u_datapath (
		.clock     (clock),
		.arst_n    (arst_n),
		.step      (step),
		.request   (request),
		.rec       (rec),
		.hash_done (hash_done),
		.new_rec   (new_rec),
		.write_en  (write_en),
		.result    (result)
	);

	memory_control #(
		.INIT_BALANCE (INIT_BALANCE),
		.HASH_ROUNDS  (HASH_ROUNDS)
	) u_memory_control (
		.clock    (clock),
		.arst_n   (arst_n),
		.step     (step),
		.account  (request.account),
		.new_rec  (new_rec),
		.write_en (write_en),
		.rec      (rec),
		.mem_done (mem_done)
	);

endmodule

/* dv/main_tb.sv */
// Runs with HASH_ROUNDS 5 and INIT_BALANCE 200; the reference hash and account rules are coded here
module main_tb;
	import bank_pkg::*;

	localparam int HASH_ROUNDS  = 5;
	localparam int INIT_BALANCE = 200;
	localparam int TIMEOUT      = 100;

	// Button positions on key
	localparam logic [1:0] WITHDRAW_BTN = 2'd0;
	localparam logic [1:0] LOAD_BTN     = 2'd1;
	localparam logic [1:0] DEPOSIT_BTN  = 2'd3;

	logic        clock;
	logic        arst_n;
	logic [9:0]  sw;
	logic [3:0]  key;
	txn_result_t result;
	logic        result_valid;

	// Reference account state
	logic [15:0] model_balance [4];
	logic [15:0] model_hash [4];
	txn_result_t last_result;
	int          result_count;
	int          checked_count;
	integer      seed;

	main #(
		.HASH_ROUNDS  (HASH_ROUNDS),
		.INIT_BALANCE (INIT_BALANCE)
	) dut (
		.clock        (clock),
		.arst_n       (arst_n),
		.sw           (sw),
		.key          (key),
		.result       (result),
		.result_valid (result_valid)
	);

	always #10 clock = ~clock;

	// Catches every strobe, even one that lands while buttons are still being pressed
	always @(negedge clock)
	begin
		if (result_valid)
		begin
			result_count <= result_count + 1;
			last_result  <= result;
		end
	end

	// Rotate left by 3 and fold in the salt, once per round
	function automatic logic [15:0] ref_hash(input logic [7:0] value);
		logic [15:0] state;
		state = {8'h00, value};
		for (int i = 0; i < HASH_ROUNDS; i++)
		begin
			state = {state[12:0], state[15:13]} ^ HASH_SALT;
		end
		return state;
	endfunction

	// Expected outcome of one transaction, model updated on success
	function automatic txn_result_t predict(input logic [1:0] acct, input txn_op_t op,
		input logic [7:0] amount, input logic [7:0] entered);
		txn_result_t expected;
		int          total;
		expected.account = acct;
		expected.status  = OK;
		expected.balance = model_balance[acct];
		total = int'(model_balance[acct]) + int'(amount);
		if (ref_hash(entered) != model_hash[acct])
			expected.status = BAD_KEY;
		else if (op == WITHDRAW && {8'h00, amount} > model_balance[acct])
			expected.status = NO_FUNDS;
		else if (op == WITHDRAW)
			expected.balance = model_balance[acct] - {8'h00, amount};
		else
			expected.balance = (total > 65535) ? 16'hFFFF : 16'(total);
		model_balance[acct] = expected.balance;
		return expected;
	endfunction

	function automatic string format_result(input txn_result_t value);
		return $sformatf("account %0d status %0d balance %0d", value.account, value.status,
			value.balance);
	endfunction

	task automatic stop_run();
		$display("TESTS FAILED");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_result(input string name, input txn_result_t expected,
		input txn_result_t actual);
		if (actual !== expected)
		begin
			$display("Error: %s expected %s actual %s", name, format_result(expected),
				format_result(actual));
			stop_run();
		end
	endtask

	// Button held low for 2 cycles, then 2 idle cycles before the next press
	task automatic press_button(input logic [1:0] idx, input logic [9:0] value);
		@(posedge clock);
		sw       <= value;
		key[idx] <= 1'b0;
		repeat (2) @(posedge clock);
		key <= 4'hF;
		repeat (2) @(posedge clock);
	endtask

	task automatic wait_result(input string name, input txn_result_t expected);
		int waited;
		waited = 0;
		while (result_count == checked_count && waited < TIMEOUT)
		begin
			@(negedge clock);
			waited++;
		end
		if (result_count == checked_count)
		begin
			$display("Timeout: no result_valid within %0d cycles in %s", TIMEOUT, name);
			stop_run();
		end
		else
		begin
			checked_count++;
			check_result(name, expected, last_result);
		end
	endtask

	task automatic expect_none(input string name);
		repeat (TIMEOUT) @(negedge clock);
		if (result_count != checked_count)
		begin
			$display("Unexpected result_valid in %s", name);
			stop_run();
		end
	endtask

	task automatic run_txn(input string name, input logic [1:0] acct, input txn_op_t op,
		input logic [7:0] amount, input logic [7:0] entered);
		txn_result_t expected;
		expected = predict(acct, op, amount, entered);
		press_button(LOAD_BTN, {acct, amount});
		press_button(LOAD_BTN, {2'b00, entered});
		press_button((op == WITHDRAW) ? WITHDRAW_BTN : DEPOSIT_BTN, sw);
		wait_result(name, expected);
	endtask

	initial
	begin
		txn_result_t expected;
		logic [1:0]  acct;
		txn_op_t     op;
		logic [7:0]  amount;
		logic [7:0]  entered;
		int          rounds;
		seed          = 30;
		clock         = 1'b0;
		arst_n        = 1'b0;
		sw            = '0;
		key           = 4'hF;
		result_count  = 0;
		checked_count = 0;
		for (int i = 0; i < 4; i++)
		begin
			model_balance[i] = 16'(INIT_BALANCE);
			model_hash[i]    = ref_hash(8'(i));
		end
		repeat (2) @(posedge clock);
		arst_n <= 1'b1;

		for (int i = 0; i < 4; i++)
			run_txn("reset balance", 2'(i), WITHDRAW, 8'd0, 8'(i));

		run_txn("wrong key", 2'd2, WITHDRAW, 8'd10, 8'h57);
		run_txn("read after wrong key", 2'd2, WITHDRAW, 8'd0, 8'd2);
		run_txn("overdraw", 2'd1, WITHDRAW, 8'd201, 8'd1);
		run_txn("withdraw", 2'd1, WITHDRAW, 8'd50, 8'd1);

		// Deposit until the balance sits at the ceiling, then once more
		rounds = 0;
		while (model_balance[3] != 16'hFFFF && rounds < 300)
		begin
			run_txn("deposit", 2'd3, DEPOSIT, 8'd255, 8'd3);
			rounds++;
		end
		run_txn("deposit at ceiling", 2'd3, DEPOSIT, 8'd255, 8'd3);

		press_button(WITHDRAW_BTN, sw);
		expect_none("start without loads");
		// Amount only, then the key load completes the request
		press_button(LOAD_BTN, {2'd0, 8'd20});
		press_button(DEPOSIT_BTN, sw);
		expect_none("start after one load");
		expected = predict(2'd0, DEPOSIT, 8'd20, 8'd0);
		press_button(LOAD_BTN, 10'd0);
		press_button(DEPOSIT_BTN, sw);
		wait_result("completed after early start", expected);

		// Extra start and load presses land while the deposit is in flight
		expected = predict(2'd1, DEPOSIT, 8'd5, 8'd1);
		press_button(LOAD_BTN, {2'd1, 8'd5});
		press_button(LOAD_BTN, 10'd1);
		press_button(DEPOSIT_BTN, sw);
		press_button(WITHDRAW_BTN, sw);
		press_button(LOAD_BTN, {2'd3, 8'd99});
		wait_result("busy transaction", expected);
		expect_none("presses while busy");
		run_txn("after busy presses", 2'd1, WITHDRAW, 8'd0, 8'd1);

		for (int n = 0; n < 300; n++)
		begin
			acct   = 2'($random(seed));
			op     = ($random(seed) & 1) ? DEPOSIT : WITHDRAW;
			amount = 8'($random(seed));
			if ({$random(seed)} % 100 < 60)
				entered = {6'd0, acct};
			else
				entered = 8'($random(seed));
			run_txn($sformatf("random %0d", n), acct, op, amount, entered);
		end

		$display("TESTS PASSED");
		$finish;
	end

endmodule

/* sim.f */
hw/bank_pkg.sv
hw/main_control.sv
hw/transaction_control.sv
hw/datapath.sv
hw/memory_control.sv
hw/main.sv
dv/main_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module main_tb -o main_tb
	out="$$(./obj_dir/main_tb)"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
